/* src/bExecPkg.sv */
// B-side execute types: word and immediate widths, ALU opcode enum, logic codes, s2 control structs
package bExecPkg;

    // ALU operand / result word
    typedef logic [31:0] word_t;

    // Instruction immediate field
    typedef logic [15:0] imm16_t;

    // Decoder opcode for the B-side ALU
    typedef enum logic [3:0] {
        addOp  = 4'd0,
        addUOp = 4'd1,
        subOp  = 4'd2,
        subUOp = 4'd3,
        sltOp  = 4'd4,
        sltUOp = 4'd5,
        andOp  = 4'd6,
        orOp   = 4'd7,
        xorOp  = 4'd8,
        norOp  = 4'd9,
        luiOp  = 4'd10
    } bAluOp_t;

    // Logic unit function codes
    localparam logic [1:0] LogicAnd = 2'd0;
    localparam logic [1:0] LogicOr  = 2'd1;
    localparam logic [1:0] LogicXor = 2'd2;
    localparam logic [1:0] LogicNor = 2'd3;

    // ALU controls carried from s1 into s2
    typedef struct packed {
        logic       addDrv;
        logic       setDrv;
        logic       logicDrv;
        logic       subtract;
        logic       signedOp;
        logic       sltSigned;
        logic       sltUnsigned;
        logic [1:0] logicFn;
        logic       lui;
        logic       kill;
    } bCtlS2_t;

    // Cop0 move controls at s2
    typedef struct packed {
        logic mvToCop0;
        logic mvFromCop0;
        logic epcSel;
        logic epcnSel;
    } bCop0S2_t;

endpackage

/* src/bAluControl.sv */
// B-side ALU control: opcode decode, s1-to-s2 control register, set result, overflow, cop0 moves
`timescale 1ns/100ps

module bAluControl import bExecPkg::*; (
    input  logic     phi1,
    input  logic     rstN,
    input  logic     stall,
    // Cancel levels from the pipeline
    input  logic     kill,
    input  logic     wrong,
    input  bAluOp_t  aluOp,
    // Cop0 move strobes
    input  logic     mvToCop0,
    input  logic     mvFromCop0,
    input  logic     epcSel,
    input  logic     epcnSel,
    // Status back from the datapath
    input  logic     addResMsb,
    input  logic     carryOut,
    input  logic     aMsb,
    input  logic     bMsb,
    // Latch enables
    output logic     latchInputs,
    output logic     cop0Latch,
    output bCtlS2_t  ctlS2,
    output logic     setRes,
    output logic     overflow,
    output logic     cop0BusDrv,
    output logic     resultDrv
);

    bCtlS2_t  ctlS1;
    bCop0S2_t cop0S1;
    bCop0S2_t cop0S2;
    logic     ovflRaw;

    // Operands only move for a live, unstalled instruction
    assign latchInputs = ~(kill | wrong | stall);
    assign cop0Latch   = mvToCop0 & latchInputs;

    // Opcode decode into driver selects and adder controls
    always_comb begin
        ctlS1         = '0;
        ctlS1.kill    = kill | wrong;
        ctlS1.logicFn = LogicAnd;
        case (aluOp)
            addOp: begin
                ctlS1.addDrv   = 1'b1;
                ctlS1.signedOp = 1'b1;
            end
            addUOp: begin
                ctlS1.addDrv = 1'b1;
            end
            subOp: begin
                ctlS1.addDrv   = 1'b1;
                ctlS1.subtract = 1'b1;
                ctlS1.signedOp = 1'b1;
            end
            subUOp: begin
                ctlS1.addDrv   = 1'b1;
                ctlS1.subtract = 1'b1;
            end
            // Set ops compare through the subtractor
            sltOp: begin
                ctlS1.setDrv    = 1'b1;
                ctlS1.subtract  = 1'b1;
                ctlS1.sltSigned = 1'b1;
            end
            sltUOp: begin
                ctlS1.setDrv      = 1'b1;
                ctlS1.subtract    = 1'b1;
                ctlS1.sltUnsigned = 1'b1;
            end
            andOp: begin
                ctlS1.logicDrv = 1'b1;
                ctlS1.logicFn  = LogicAnd;
            end
            orOp: begin
                ctlS1.logicDrv = 1'b1;
                ctlS1.logicFn  = LogicOr;
            end
            xorOp: begin
                ctlS1.logicDrv = 1'b1;
                ctlS1.logicFn  = LogicXor;
            end
            norOp: begin
                ctlS1.logicDrv = 1'b1;
                ctlS1.logicFn  = LogicNor;
            end
            // lui result is the pre-shifted B operand
            luiOp: begin
                ctlS1.logicDrv = 1'b1;
                ctlS1.lui      = 1'b1;
            end
            default: begin
                // Unused codes drive nothing
                ctlS1.logicFn = LogicAnd;
            end
        endcase
    end

    assign cop0S1 = '{
        mvToCop0:   mvToCop0,
        mvFromCop0: mvFromCop0,
        epcSel:     epcSel,
        epcnSel:    epcnSel
    };

    // s1 to s2 register, held under stall
    // Kill still loads so it reaches s2
    always_ff @(posedge phi1) begin
        if (!rstN) begin
            ctlS2  <= '0;
            cop0S2 <= '0;
        end else if (!stall) begin
            ctlS2  <= ctlS1;
            cop0S2 <= cop0S1;
        end
    end

    // Same-sign operands with a sum of the other sign
    assign ovflRaw = (aMsb & bMsb & ~addResMsb) | (~aMsb & ~bMsb & addResMsb);

    // Signed compare corrects the sign with overflow
    // unsigned compare is a borrow, i.e. no carry out
    assign setRes = ((addResMsb ^ ovflRaw) & ctlS2.sltSigned) |
                    (~carryOut & ctlS2.sltUnsigned);

    // Only trapping add/sub report overflow
    assign overflow = ovflRaw & ctlS2.signedOp & ~ctlS2.kill;

    assign resultDrv = (ctlS2.addDrv | ctlS2.setDrv | ctlS2.logicDrv) & ~ctlS2.kill;

    // EPC sources own the cop0 bus when selected
    assign cop0BusDrv = cop0S2.mvFromCop0 & ~cop0S2.epcSel & ~cop0S2.epcnSel;

endmodule

/* src/bOperandLatch.sv */
// B-side operand block: immediate extension, B operand select, operand and cop0 data latches
`timescale 1ns/100ps

module bOperandLatch import bExecPkg::*; #(
    parameter int DataWidth = 32
) (
    input  logic                 phi1,
    input  logic                 rstN,
    // Enables from the control block
    input  logic                 latchInputs,
    input  logic                 cop0Latch,
    // Immediate handling from decode
    input  logic                 useImm,
    input  logic                 immSigned,
    input  logic                 immShift16,
    input  imm16_t               imm,
    // Register read buses
    input  logic [DataWidth-1:0] sBus,
    input  logic [DataWidth-1:0] tBus,
    output logic [DataWidth-1:0] aOperand,
    output logic [DataWidth-1:0] bOperand,
    output logic [DataWidth-1:0] cop0Data
);

    logic [DataWidth-1:0] immExt;
    logic [DataWidth-1:0] immOut;
    logic [DataWidth-1:0] bSel;

    // Sign or zero extension of the 16-bit field
    assign immExt = immSigned ? DataWidth'($signed(imm)) : DataWidth'(imm);

    // lui form puts the field in the upper half
    assign immOut = immShift16 ? (immExt << 16) : immExt;

    assign bSel = useImm ? immOut : tBus;

    // Operands hold on kill, wrong or stall to save toggles
    always_ff @(posedge phi1) begin
        if (!rstN) begin
            aOperand <= '0;
            bOperand <= '0;
        end else if (latchInputs) begin
            aOperand <= sBus;
            bOperand <= bSel;
        end
    end

    // Move-to-cop0 data, taken straight off T
    always_ff @(posedge phi1) begin
        if (!rstN) begin
            cop0Data <= '0;
        end else if (cop0Latch) begin
            cop0Data <= tBus;
        end
    end

endmodule

/* src/bAluDatapath.sv */
// B-side ALU datapath: adder with B inversion, logic unit, lui path and result driver select
`timescale 1ns/100ps

module bAluDatapath import bExecPkg::*; #(
    parameter int DataWidth = 32
) (
    input  bCtlS2_t              ctlS2,
    input  logic [DataWidth-1:0] aOperand,
    input  logic [DataWidth-1:0] bOperand,
    // Compare bit from the control block
    input  logic                 setRes,
    output logic [DataWidth-1:0] result,
    // Status for set and overflow logic
    output logic                 addResMsb,
    output logic                 carryOut,
    output logic                 aMsb,
    output logic                 bMsb
);

    logic [DataWidth-1:0] bAdd;
    logic [DataWidth-1:0] sum;
    logic [DataWidth-1:0] logicRes;
    logic [DataWidth-1:0] logicOut;
    logic [DataWidth-1:0] setWord;

    // Subtract is A + ~B + 1
    assign bAdd = ctlS2.subtract ? ~bOperand : bOperand;

    assign {carryOut, sum} = {1'b0, aOperand} + {1'b0, bAdd} +
                             {{DataWidth{1'b0}}, ctlS2.subtract};

    assign addResMsb = sum[DataWidth-1];
    assign aMsb      = aOperand[DataWidth-1];
    // B msb as seen by the adder
    assign bMsb      = bAdd[DataWidth-1];

    // Logic unit
    always_comb begin
        case (ctlS2.logicFn)
            LogicAnd: logicRes = aOperand & bOperand;
            LogicOr:  logicRes = aOperand | bOperand;
            LogicXor: logicRes = aOperand ^ bOperand;
            LogicNor: logicRes = ~(aOperand | bOperand);
            default:  logicRes = aOperand & bOperand;
        endcase
    end

    // Immediate already shifted up by the operand block
    assign logicOut = ctlS2.lui ? bOperand : logicRes;

    // Compare result sits in bit 0
    assign setWord = DataWidth'(setRes);

    // One driver at a time, zero when none selected
    assign result = ({DataWidth{ctlS2.addDrv}}   & sum)     |
                    ({DataWidth{ctlS2.setDrv}}   & setWord) |
                    ({DataWidth{ctlS2.logicDrv}} & logicOut);

endmodule

/* src/bExecuteUnit.sv */
// B-side execute unit top: control, operand latch and ALU datapath
`timescale 1ns/100ps

module bExecuteUnit import bExecPkg::*; #(
    parameter int DataWidth = 32
) (
    input  logic                 phi1,
    input  logic                 rstN,
    // s1 instruction fields
    input  bAluOp_t              aluOp,
    input  logic                 useImm,
    input  logic                 immSigned,
    input  logic                 immShift16,
    input  imm16_t               imm,
    input  logic [DataWidth-1:0] sBus,
    input  logic [DataWidth-1:0] tBus,
    // Cancel and stall
    input  logic                 kill,
    input  logic                 wrong,
    input  logic                 stall,
    // Cop0 strobes
    input  logic                 mvToCop0,
    input  logic                 mvFromCop0,
    input  logic                 epcSel,
    input  logic                 epcnSel,
    output logic [DataWidth-1:0] result,
    output logic                 resultDrv,
    output logic                 overflow,
    output logic                 cop0BusDrv,
    output logic [DataWidth-1:0] cop0Data
);

    bCtlS2_t              ctlS2;
    logic                 latchInputs;
    logic                 cop0Latch;
    logic                 setRes;
    logic                 addResMsb;
    logic                 carryOut;
    logic                 aMsb;
    logic                 bMsb;
    logic [DataWidth-1:0] aOperand;
    logic [DataWidth-1:0] bOperand;

    bAluControl bAluControl_inst (
        .phi1        (phi1),
        .rstN        (rstN),
        .stall       (stall),
        .kill        (kill),
        .wrong       (wrong),
        .aluOp       (aluOp),
        .mvToCop0    (mvToCop0),
        .mvFromCop0  (mvFromCop0),
        .epcSel      (epcSel),
        .epcnSel     (epcnSel),
        .addResMsb   (addResMsb),
        .carryOut    (carryOut),
        .aMsb        (aMsb),
        .bMsb        (bMsb),
        .latchInputs (latchInputs),
        .cop0Latch   (cop0Latch),
        .ctlS2       (ctlS2),
        .setRes      (setRes),
        .overflow    (overflow),
        .cop0BusDrv  (cop0BusDrv),
        .resultDrv   (resultDrv)
    );

    // Immediate controls go straight from decode
    bOperandLatch #(
        .DataWidth (DataWidth)
    ) bOperandLatch_inst (
        .phi1        (phi1),
        .rstN        (rstN),
        .latchInputs (latchInputs),
        .cop0Latch   (cop0Latch),
        .useImm      (useImm),
        .immSigned   (immSigned),
        .immShift16  (immShift16),
        .imm         (imm),
        .sBus        (sBus),
        .tBus        (tBus),
        .aOperand    (aOperand),
        .bOperand    (bOperand),
        .cop0Data    (cop0Data)
    );

    bAluDatapath #(
        .DataWidth (DataWidth)
    ) bAluDatapath_inst (
        .ctlS2     (ctlS2),
        .aOperand  (aOperand),
        .bOperand  (bOperand),
        .setRes    (setRes),
        .result    (result),
        .addResMsb (addResMsb),
        .carryOut  (carryOut),
        .aMsb      (aMsb),
        .bMsb      (bMsb)
    );

endmodule

/* tb/tbExecuteUnit.sv */
// Testbench for the B-side execute unit: clock, reset, reference model, directed tests, checks
`timescale 1ns/100ps

module tbExecuteUnit import bExecPkg::*; ();

    localparam int CycleLimit = 2000;

    logic    phi1;
    logic    rstN;
    bAluOp_t aluOp;
    logic    useImm;
    logic    immSigned;
    logic    immShift16;
    imm16_t  imm;
    word_t   sBus;
    word_t   tBus;
    logic    kill;
    logic    wrong;
    logic    stall;
    logic    mvToCop0;
    logic    mvFromCop0;
    logic    epcSel;
    logic    epcnSel;
    word_t   result;
    logic    resultDrv;
    logic    overflow;
    logic    cop0BusDrv;
    word_t   cop0Data;
    int      cycleCount;

    bExecuteUnit #(
        .DataWidth (32)
    ) bExecuteUnit_inst (
        .phi1       (phi1),
        .rstN       (rstN),
        .aluOp      (aluOp),
        .useImm     (useImm),
        .immSigned  (immSigned),
        .immShift16 (immShift16),
        .imm        (imm),
        .sBus       (sBus),
        .tBus       (tBus),
        .kill       (kill),
        .wrong      (wrong),
        .stall      (stall),
        .mvToCop0   (mvToCop0),
        .mvFromCop0 (mvFromCop0),
        .epcSel     (epcSel),
        .epcnSel    (epcnSel),
        .result     (result),
        .resultDrv  (resultDrv),
        .overflow   (overflow),
        .cop0BusDrv (cop0BusDrv),
        .cop0Data   (cop0Data)
    );

    // 8 ns clock
    always #4 phi1 = ~phi1;

    // Run limit of about four times the test length
    always @(posedge phi1) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the run went past %0d clock cycles", CycleLimit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    task automatic checkValue(input string testName, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", testName, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch");
        end
    endtask

    // Expected immediate after extension and optional move to the upper half
    function automatic word_t extendImm(input imm16_t im, input logic sgn, input logic sh16);
        word_t e;
        e = sgn ? {{16{im[15]}}, im} : {16'h0, im};
        if (sh16) begin
            e = {e[15:0], 16'h0};
        end
        return e;
    endfunction

    // Expected result word for one operation
    function automatic word_t modelResult(input bAluOp_t op, input word_t a, input word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic        [63:0] wide;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        case (op)
            addOp, addUOp: wide = {32'h0, a} + {32'h0, b};
            subOp, subUOp: wide = {32'h0, a} - {32'h0, b};
            sltOp:  wide = {63'h0, sa < sb};
            sltUOp: wide = {63'h0, {32'h0, a} < {32'h0, b}};
            andOp:  wide = {32'h0, a & b};
            orOp:   wide = {32'h0, a | b};
            xorOp:  wide = {32'h0, a ^ b};
            norOp:  wide = {32'h0, ~(a | b)};
            luiOp:  wide = {32'h0, b};
            default: wide = '0;
        endcase
        return wide[31:0];
    endfunction

    // Signed add/sub overflow when the exact result does not fit in 32 bits
    function automatic logic modelOverflow(input bAluOp_t op, input word_t a, input word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] wide;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        case (op)
            addOp: wide = sa + sb;
            subOp: wide = sa - sb;
            default: wide = '0;
        endcase
        return wide != {{32{wide[31]}}, wide[31:0]};
    endfunction

    task automatic presentOp(input bAluOp_t op, input word_t a, input word_t t,
                             input logic ui, input logic isg, input logic sh,
                             input imm16_t im);
        aluOp      = op;
        sBus       = a;
        tBus       = t;
        useImm     = ui;
        immSigned  = isg;
        immShift16 = sh;
        imm        = im;
    endtask

    // Issue now, check one clock later at the next falling edge
    task automatic runOp(input string name, input bAluOp_t op, input word_t a, input word_t t,
                         input logic ui, input logic isg, input logic sh, input imm16_t im);
        word_t b;
        b = ui ? extendImm(im, isg, sh) : t;
        presentOp(op, a, t, ui, isg, sh, im);
        @(negedge phi1);
        checkValue({name, " result"}, 64'(modelResult(op, a, b)), 64'(result));
        checkValue({name, " resultDrv"}, 64'(1), 64'(resultDrv));
        checkValue({name, " overflow"}, 64'(modelOverflow(op, a, b)), 64'(overflow));
    endtask

    task automatic regOp(input string name, input bAluOp_t op, input word_t a, input word_t t);
        runOp(name, op, a, t, 1'b0, 1'b0, 1'b0, 16'h0);
    endtask

    task automatic testArithLogic();
        bAluOp_t op;
        for (int i = 0; i <= 10; i++) begin
            op = bAluOp_t'(i);
            for (int n = 0; n < 40; n++) begin
                regOp({"arithLogic ", op.name()}, op, $urandom(), $urandom());
            end
        end
    endtask

    task automatic testImmediates();
        runOp("immSignedNeg", addOp, 32'h0000_0100, 32'hdead_beef, 1'b1, 1'b1, 1'b0, 16'hfff0);
        runOp("immSignedPos", addOp, 32'h1234_0000, 32'h0, 1'b1, 1'b1, 1'b0, 16'h7001);
        runOp("immUnsigned", orOp, 32'h0f00_0000, 32'hffff_ffff, 1'b1, 1'b0, 1'b0, 16'h8001);
        runOp("immShift16", luiOp, 32'h5555_5555, 32'h0, 1'b1, 1'b0, 1'b1, 16'h1234);
        runOp("immShiftOr", orOp, 32'h0000_00aa, 32'h0, 1'b1, 1'b0, 1'b1, 16'hbeef);
    endtask

    task automatic testSetOverflow();
        regOp("sltMaxMin", sltOp, 32'h7fff_ffff, 32'h8000_0000);
        regOp("sltMinMax", sltOp, 32'h8000_0000, 32'h7fff_ffff);
        regOp("sltEqual", sltOp, 32'h8000_0000, 32'h8000_0000);
        regOp("sltUMaxMin", sltUOp, 32'h7fff_ffff, 32'h8000_0000);
        regOp("sltUMinMax", sltUOp, 32'h8000_0000, 32'h7fff_ffff);
        regOp("sltUEqual", sltUOp, 32'hffff_ffff, 32'hffff_ffff);
        // Signed forms flag overflow, unsigned forms never do
        regOp("addOverflow", addOp, 32'h7fff_ffff, 32'h1);
        regOp("addUNoOverflow", addUOp, 32'h7fff_ffff, 32'h1);
        regOp("subOverflow", subOp, 32'h8000_0000, 32'h1);
        regOp("subUNoOverflow", subUOp, 32'h8000_0000, 32'h1);
        regOp("addNegOverflow", addOp, 32'h8000_0000, 32'hffff_ffff);
    endtask

    task automatic testKillWrong();
        // Held operands would overflow if the cancel were ignored
        regOp("killSetup", addOp, 32'h7fff_ffff, 32'h1);
        presentOp(addOp, 32'h7fff_ffff, 32'h7fff_ffff, 1'b0, 1'b0, 1'b0, 16'h0);
        kill = 1'b1;
        @(negedge phi1);
        kill = 1'b0;
        checkValue("kill resultDrv", 64'(0), 64'(resultDrv));
        checkValue("kill overflow", 64'(0), 64'(overflow));
        presentOp(subOp, 32'h8000_0000, 32'h1, 1'b0, 1'b0, 1'b0, 16'h0);
        wrong = 1'b1;
        @(negedge phi1);
        wrong = 1'b0;
        checkValue("wrong resultDrv", 64'(0), 64'(resultDrv));
        checkValue("wrong overflow", 64'(0), 64'(overflow));
        regOp("afterKill", addOp, 32'h0000_0010, 32'h0000_0020);
        regOp("afterKillSub", subOp, 32'h0000_0005, 32'h0000_0007);
    endtask

    task automatic testStall();
        word_t held;
        held = modelResult(xorOp, 32'hf0f0_1234, 32'h0ff0_4321);
        regOp("stallSetup", xorOp, 32'hf0f0_1234, 32'h0ff0_4321);
        // Different instruction sits at s1 while stalled
        presentOp(subOp, 32'h1, 32'h2, 1'b0, 1'b0, 1'b0, 16'h0);
        stall = 1'b1;
        repeat (3) begin
            @(negedge phi1);
            checkValue("stall hold result", 64'(held), 64'(result));
            checkValue("stall hold resultDrv", 64'(1), 64'(resultDrv));
        end
        stall = 1'b0;
        regOp("stallRelease", addOp, 32'h0000_1000, 32'h0000_0234);
    endtask

    task automatic testCop0();
        presentOp(addOp, 32'h1, 32'hcafe_f00d, 1'b0, 1'b0, 1'b0, 16'h0);
        mvToCop0 = 1'b1;
        @(negedge phi1);
        mvToCop0 = 1'b0;
        checkValue("mvToCop0 data", 64'(32'hcafe_f00d), 64'(cop0Data));
        checkValue("mvToCop0 busDrv", 64'(0), 64'(cop0BusDrv));
        // New T value must not reach cop0Data without a move strobe
        tBus       = 32'h1357_9bdf;
        mvFromCop0 = 1'b1;
        @(negedge phi1);
        checkValue("mvFromCop0 busDrv", 64'(1), 64'(cop0BusDrv));
        epcSel = 1'b1;
        @(negedge phi1);
        checkValue("mvFromCop0 epcSel", 64'(0), 64'(cop0BusDrv));
        epcSel  = 1'b0;
        epcnSel = 1'b1;
        @(negedge phi1);
        checkValue("mvFromCop0 epcnSel", 64'(0), 64'(cop0BusDrv));
        epcnSel    = 1'b0;
        mvFromCop0 = 1'b0;
        @(negedge phi1);
        checkValue("cop0 idle busDrv", 64'(0), 64'(cop0BusDrv));
        checkValue("cop0 data held", 64'(32'hcafe_f00d), 64'(cop0Data));
    endtask

    initial begin
        void'($urandom(32'h2d99));
        cycleCount = 0;
        phi1       = 1'b0;
        rstN       = 1'b0;
        kill       = 1'b0;
        wrong      = 1'b0;
        stall      = 1'b0;
        mvToCop0   = 1'b0;
        mvFromCop0 = 1'b0;
        epcSel     = 1'b0;
        epcnSel    = 1'b0;
        presentOp(addOp, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 16'h0);
        repeat (2) @(negedge phi1);
        rstN = 1'b1;
        // Cleared s2 registers drive nothing
        checkValue("reset result", 64'(0), 64'(result));
        checkValue("reset resultDrv", 64'(0), 64'(resultDrv));
        checkValue("reset overflow", 64'(0), 64'(overflow));
        checkValue("reset cop0BusDrv", 64'(0), 64'(cop0BusDrv));
        testArithLogic();
        testImmediates();
        testSetOverflow();
        testKillWrong();
        testStall();
        testCop0();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
src/bExecPkg.sv
src/bAluControl.sv
src/bOperandLatch.sv
src/bAluDatapath.sv
src/bExecuteUnit.sv
tb/tbExecuteUnit.sv

/* Makefile */
# Verilator build and run for the B-side execute unit

.PHONY: all run lint clean

all: run

run:
	verilator --binary -j 0 --top-module tbExecuteUnit -f all.f -o simExecuteUnit
	./obj_dir/simExecuteUnit 2>&1 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module tbExecuteUnit -f all.f

clean:
	rm -rf obj_dir sim.log
